/* bench/game_display_tests.svh */
`ifndef GAME_DISPLAY_TESTS_SVH
`define GAME_DISPLAY_TESTS_SVH

function automatic led_rgb_t expected_lamp(input color_code_e color);
    led_rgb_t rgb;
    rgb.r = (color == RED);
    rgb.g = (color == GREEN);
    rgb.b = (color == BLUE);
    return rgb;
endfunction

function automatic seg_t expected_pattern(input digit_t d);
    case (d)                                    // Segments a..g
        3'd1:    return 7'b0110000;
        3'd2:    return 7'b1101101;
        3'd3:    return 7'b1111001;
        3'd4:    return 7'b0110011;
        3'd5:    return 7'b1011011;
        default: return 7'b0000000;
    endcase
endfunction

function automatic logic [7:0] expected_char(input int msg_code, input int line, input int idx);
    string txt;
    if (msg_code != 1 && msg_code != 2) begin
        return CHR_SPACE;
    end
    if (line == 0) begin
        txt = (msg_code == 1) ? " P1 Win" : " P2 Win";
        return (idx < txt.len()) ? txt[idx] : CHR_SPACE;
    end
    return (idx inside {1, 2, 3, 5, 6, 7}) ? CHR_HEART : CHR_SPACE;
endfunction

function automatic lcd_bus_t expected_lcd_byte(input logic rs, input logic [7:0] data);
    lcd_bus_t b;
    b.e    = 1'b1;
    b.rs   = rs;
    b.rw   = 1'b0;
    b.data = data;
    return b;
endfunction

task automatic make_order(input int n);
    int i;
    int j;
    int tmp;
    for (i = 0; i < n; i++) order[i] = i;
    for (i = n - 1; i > 0; i--) begin
        j        = $urandom_range(i, 0);
        tmp      = order[i];
        order[i] = order[j];
        order[j] = tmp;
    end
endtask

task automatic wait_position(input int lo, input int hi, output bit ok);
    int n;
    int k;
    ok = 1'b0;
    for (n = 0; n < POS_TIMEOUT && !ok; n++) begin
        @(negedge clk);
        for (k = lo; k <= hi; k++) begin
            if (pos_en == ~(pos_en_t'(1) << k)) ok = 1'b1;
        end
    end
    if (!ok) report_timeout($sformatf("scan position %0d to %0d", lo, hi));
endtask

// One byte per character cycle and one per run of equal commands
task automatic capture_lcd_byte(output lcd_bus_t b, output bit ok);
    int n;
    ok = 1'b0;
    for (n = 0; n < LCD_TIMEOUT && !ok; n++) begin
        @(negedge clk);
        if (lcd.e && (lcd.rs || !lcd_prev.e || lcd != lcd_prev)) begin
            b  = lcd;
            ok = 1'b1;
        end
        lcd_prev = lcd;
    end
    if (!ok) report_timeout("an LCD byte");
endtask

task automatic expect_lcd_byte(input string test, input lcd_bus_t exp, output bit ok);
    lcd_bus_t b;
    capture_lcd_byte(b, ok);
    if (ok) check_lcd_byte(test, exp, b);
endtask

task automatic find_lcd_command(input logic [7:0] cmd, output bit ok);
    lcd_bus_t b;
    int       n;
    bit       got;
    ok = 1'b0;
    for (n = 0; n < SEARCH_LIMIT && !ok; n++) begin
        capture_lcd_byte(b, got);
        if (!got) return;
        if (!b.rs && b.data == cmd) ok = 1'b1;
    end
    if (!ok) begin
        lcd_errs++;
        $display("LCD command %h did not appear within %0d bytes", cmd, SEARCH_LIMIT);
    end
endtask

task automatic reset_values_hold;
    int i;
    rst    = 1'b0;
    color1 = RED;                               // Lit inputs held in reset
    color2 = BLUE;
    digit1 = 3'd1;
    digit2 = 3'd5;
    for (i = 0; i < RESET_CYCLES; i++) begin
        @(negedge clk);
        check_lamp("reset lamp 1", '0, lamp1);
        check_lamp("reset lamp 2", '0, lamp2);
        check_seg("reset seg", 7'b0000000, seg);
        check_pos_en("reset pos_en", '1, pos_en);
        check_lcd_byte("reset lcd", '0, lcd);
    end
    rst    = 1'b1;
    color1 = OFF;
    color2 = OFF;
    digit1 = '0;
    digit2 = '0;
    @(negedge clk);
    check_lamp("after reset lamp 1", '0, lamp1);
    check_lamp("after reset lamp 2", '0, lamp2);
    check_seg("after reset seg", 7'b0000000, seg);
    check_lcd_byte("after reset lcd", '0, lcd);
endtask

task automatic lamp_colors_decode;
    int          i;
    color_code_e c1;
    color_code_e c2;
    make_order(4);
    for (i = 0; i < 4; i++) begin
        c1 = color_code_e'(2'(order[i]));
        c2 = color_code_e'(2'(order[(i + 1) % 4]));
        @(negedge clk);
        color1 = c1;
        color2 = c2;
        repeat (2) @(negedge clk);
        check_lamp($sformatf("lamp 1 colour %0d", c1), expected_lamp(c1), lamp1);
        check_lamp($sformatf("lamp 2 colour %0d", c2), expected_lamp(c2), lamp2);
    end
endtask

task automatic digit_scan_patterns;
    int     i;
    digit_t d1;
    digit_t d2;
    bit     ok;
    make_order(8);
    for (i = 0; i < 8; i++) begin
        d1 = digit_t'(order[i]);
        d2 = digit_t'(order[(i + 3) % 8]);
        @(negedge clk);
        digit1 = d1;
        digit2 = d2;
        repeat (2) @(negedge clk);              // Decoder and scanner registers
        wait_position(0, 0, ok);
        if (!ok) return;
        check_seg($sformatf("digit 1 value %0d", d1), expected_pattern(d1), seg);
        wait_position(NUM_POS - 1, NUM_POS - 1, ok);
        if (!ok) return;
        check_seg($sformatf("digit 2 value %0d", d2), expected_pattern(d2), seg);
        wait_position(1, NUM_POS - 2, ok);
        if (!ok) return;
        check_seg("middle position", 7'b0000000, seg);
    end
endtask

task automatic power_up_commands;
    bit ok;
    apply_reset();
    expect_lcd_byte("power-up function set", expected_lcd_byte(1'b0, CMD_FUNCTION), ok);
    if (!ok) return;
    expect_lcd_byte("power-up entry mode", expected_lcd_byte(1'b0, CMD_ENTRY), ok);
    if (!ok) return;
    expect_lcd_byte("power-up display on", expected_lcd_byte(1'b0, CMD_DISPLAY), ok);
    if (!ok) return;
    expect_lcd_byte("power-up line 1", expected_lcd_byte(1'b0, CMD_LINE1), ok);
endtask

task automatic message_lines;
    int m;
    int i;
    bit ok;
    for (m = 0; m < 4; m++) begin
        lcd_msg = lcd_msg_e'(2'(m));            // Held for the whole refresh
        find_lcd_command(CMD_LINE1, ok);
        if (!ok) return;
        for (i = 0; i < 20; i++) begin
            expect_lcd_byte($sformatf("message %0d line 1 col %0d", m, i),
                            expected_lcd_byte(1'b1, expected_char(m, 0, i)), ok);
            if (!ok) return;
        end
        expect_lcd_byte($sformatf("message %0d line 2 address", m),
                        expected_lcd_byte(1'b0, CMD_LINE2), ok);
        if (!ok) return;
        for (i = 0; i < 20; i++) begin
            expect_lcd_byte($sformatf("message %0d line 2 col %0d", m, i),
                            expected_lcd_byte(1'b1, expected_char(m, 1, i)), ok);
            if (!ok) return;
        end
    end
endtask

task automatic refresh_commands;
    lcd_bus_t b;
    int       i;
    bit       ok;
    find_lcd_command(CMD_LINE2, ok);
    if (!ok) return;
    for (i = 0; i < 20; i++) begin
        capture_lcd_byte(b, ok);                // Skip line 2 text
        if (!ok) return;
    end
    expect_lcd_byte("refresh return home", expected_lcd_byte(1'b0, CMD_HOME), ok);
    if (!ok) return;
    expect_lcd_byte("refresh clear display", expected_lcd_byte(1'b0, CMD_CLEAR), ok);
    if (!ok) return;
    expect_lcd_byte("refresh line 1", expected_lcd_byte(1'b0, CMD_LINE1), ok);
endtask

`endif

/* bench/tb_game_display.sv */
`default_nettype none

module tb_game_display;

    timeunit 1ns;
    timeprecision 1ns;

    import board_pkg::*;

    localparam int RESET_CYCLES = 16;
    localparam int LCD_TIMEOUT  = 1000;         // Longer than RETURN_HOME
    localparam int POS_TIMEOUT  = 2 * NUM_POS;
    localparam int SEARCH_LIMIT = 64;           // Byte count above one refresh

    logic        clk;
    logic        rst;
    color_code_e color1;
    color_code_e color2;
    digit_t      digit1;
    digit_t      digit2;
    lcd_msg_e    lcd_msg;
    led_rgb_t    lamp1;
    led_rgb_t    lamp2;
    seg_t        seg;
    pos_en_t     pos_en;
    lcd_bus_t    lcd;

    int lamp_errs;
    int seg_errs;
    int pos_errs;
    int lcd_errs;
    int timeout_errs;

    int       order [8];                        // Shuffled stimulus values
    lcd_bus_t lcd_prev;                         // Last sampled bus

    game_display_top game_display_top_inst (
        .clk     (clk),
        .rst     (rst),
        .color1  (color1),
        .color2  (color2),
        .digit1  (digit1),
        .digit2  (digit2),
        .lcd_msg (lcd_msg),
        .lamp1   (lamp1),
        .lamp2   (lamp2),
        .seg     (seg),
        .pos_en  (pos_en),
        .lcd     (lcd)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_lamp(input string test, input led_rgb_t exp, input led_rgb_t act);
        if (act !== exp) begin
            lamp_errs++;
            $display("ERROR %s: expected rgb=%b, actual rgb=%b", test, exp, act);
        end
    endtask

    task automatic check_seg(input string test, input seg_t exp, input seg_t act);
        if (act !== exp) begin
            seg_errs++;
            $display("ERROR %s: expected seg=%b, actual seg=%b", test, exp, act);
        end
    endtask

    task automatic check_pos_en(input string test, input pos_en_t exp, input pos_en_t act);
        if (act !== exp) begin
            pos_errs++;
            $display("ERROR %s: expected pos_en=%b, actual pos_en=%b", test, exp, act);
        end
    endtask

    task automatic check_lcd_byte(input string test, input lcd_bus_t exp, input lcd_bus_t act);
        if (act !== exp) begin
            lcd_errs++;
            $display("ERROR %s: expected e/rs/rw/data=%b/%b/%b/%h, actual %b/%b/%b/%h",
                     test, exp.e, exp.rs, exp.rw, exp.data, act.e, act.rs, act.rw, act.data);
        end
    endtask

    task automatic report_timeout(input string what);
        timeout_errs++;
        $display("Timed out waiting for %s", what);
    endtask

    task automatic apply_reset;
        rst = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst      = 1'b1;
        lcd_prev = '0;
    endtask

    initial begin : main
        int total;
        void'($urandom(32));
        rst      = 1'b0;
        color1   = OFF;
        color2   = OFF;
        digit1   = '0;
        digit2   = '0;
        lcd_msg  = MSG_BLANK;
        lcd_prev = '0;

        reset_values_hold();
        lamp_colors_decode();
        digit_scan_patterns();
        power_up_commands();
        message_lines();
        refresh_commands();

        total = lamp_errs + seg_errs + pos_errs + lcd_errs + timeout_errs;
        $display("error counts: lamp %0d, seg %0d, pos_en %0d, lcd %0d, timeouts %0d",
                 lamp_errs, seg_errs, pos_errs, lcd_errs, timeout_errs);
        if (total == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    `include "game_display_tests.svh"

endmodule

`default_nettype wire

/* common/board_pkg.sv */
`default_nettype none

package board_pkg;

    typedef enum logic [1:0] {
        OFF   = 2'd0,
        RED   = 2'd1,
        GREEN = 2'd2,
        BLUE  = 2'd3
    } color_code_e;

    typedef struct packed {
        logic r;
        logic g;
        logic b;
    } led_rgb_t;

    typedef logic [2:0] digit_t;                // 1 to 5 shown, rest blank

    typedef logic [6:0] seg_t;                  // Segments a..g, a is msb

    localparam seg_t SEG_BLANK = 7'b000_0000;

    localparam seg_t SEG_DIGIT [1:5] = '{
        7'b011_0000,                            // 1
        7'b110_1101,                            // 2
        7'b111_1001,                            // 3
        7'b011_0011,                            // 4
        7'b101_1011                             // 5
    };

    localparam int NUM_POS = 8;
    localparam int POS_W   = $clog2(NUM_POS);

    typedef logic [NUM_POS-1:0] pos_en_t;       // Active low

    typedef enum logic [1:0] {
        MSG_BLANK  = 2'd0,
        MSG_P1_WIN = 2'd1,
        MSG_P2_WIN = 2'd2
    } lcd_msg_e;

    typedef struct packed {
        logic       e;
        logic       rs;
        logic       rw;
        logic [7:0] data;
    } lcd_bus_t;

    typedef enum logic [2:0] {
        POWER_DELAY,
        FUNCTION_SET,
        ENTRY_MODE,
        DISPLAY_ON,
        LINE1,
        LINE2,
        RETURN_HOME,
        CLEAR_DISPLAY
    } lcd_state_e;

    // Last interval value of each state
    localparam int T_POWER = 70;
    localparam int T_CMD   = 30;
    localparam int T_LINE  = 20;
    localparam int T_HOME  = 400;
    localparam int T_CLEAR = 200;

    localparam int IVL_W = 9;                   // Holds T_HOME
    typedef logic [IVL_W-1:0] interval_t;

    localparam logic [7:0] CMD_FUNCTION = 8'h3C;
    localparam logic [7:0] CMD_ENTRY    = 8'h06;
    localparam logic [7:0] CMD_DISPLAY  = 8'h0C;
    localparam logic [7:0] CMD_LINE1    = 8'h80;
    localparam logic [7:0] CMD_LINE2    = 8'hC0;
    localparam logic [7:0] CMD_HOME     = 8'h02;
    localparam logic [7:0] CMD_CLEAR    = 8'h01;

    localparam logic [7:0] CHR_SPACE = 8'h20;
    localparam logic [7:0] CHR_HEART = 8'h9D;

    localparam int LINE_TEXT_LEN = 10;

endpackage

`default_nettype wire

/* lcd/lcd_message_rom.sv */
`default_nettype none

module lcd_message_rom (
    input  wire board_pkg::lcd_msg_e msg,
    input  wire                  line,
    input  wire [3:0]            col,
    output logic [7:0]           chr
);

    import board_pkg::*;

    logic show_text;

    assign show_text = (msg == MSG_P1_WIN || msg == MSG_P2_WIN)
                    && (col < 4'(LINE_TEXT_LEN));

    always_comb begin
        chr = CHR_SPACE;
        if (show_text) begin
            if (!line) begin
                case (col)                      // " P1 Win" / " P2 Win"
                    4'd1:    chr = 8'h50;
                    4'd2:    chr = (msg == MSG_P1_WIN) ? 8'h31 : 8'h32;
                    4'd4:    chr = 8'h57;
                    4'd5:    chr = 8'h69;
                    4'd6:    chr = 8'h6E;
                    default: chr = CHR_SPACE;
                endcase
            end else begin
                case (col)                      // Two groups of three hearts
                    4'd1, 4'd2, 4'd3: chr = CHR_HEART;
                    4'd5, 4'd6, 4'd7: chr = CHR_HEART;
                    default:          chr = CHR_SPACE;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* lcd/lcd_sequencer.sv */
`default_nettype none

module lcd_sequencer (
    input  wire                  clk,
    input  wire                  rst,
    input  wire board_pkg::lcd_msg_e msg,
    output board_pkg::lcd_bus_t  lcd
);

    import board_pkg::*;

    lcd_state_e state_q;
    interval_t  ivl_q;
    interval_t  limit;
    interval_t  col_idx;
    lcd_msg_e   msg_q;
    logic       addr_cycle;
    logic       rom_line;
    logic [3:0] rom_col;
    logic [7:0] rom_chr;

    always_comb begin
        case (state_q)
            POWER_DELAY:                          limit = interval_t'(T_POWER);
            FUNCTION_SET, ENTRY_MODE, DISPLAY_ON: limit = interval_t'(T_CMD);
            LINE1, LINE2:                         limit = interval_t'(T_LINE);
            RETURN_HOME:                          limit = interval_t'(T_HOME);
            default:                              limit = interval_t'(T_CLEAR);
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state_q <= POWER_DELAY;
            ivl_q   <= '0;
        end else if (ivl_q == limit) begin
            ivl_q <= '0;
            case (state_q)
                POWER_DELAY:   state_q <= FUNCTION_SET;
                FUNCTION_SET:  state_q <= ENTRY_MODE;
                ENTRY_MODE:    state_q <= DISPLAY_ON;
                DISPLAY_ON:    state_q <= LINE1;
                LINE1:         state_q <= LINE2;
                LINE2:         state_q <= RETURN_HOME;
                RETURN_HOME:   state_q <= CLEAR_DISPLAY;
                CLEAR_DISPLAY: state_q <= LINE1;   // Refresh loop
            endcase
        end else begin
            ivl_q <= ivl_q + 1'b1;
        end
    end

    assign addr_cycle = (state_q == LINE1 || state_q == LINE2) && (ivl_q == '0);

    // Whole line comes from one message
    always_ff @(posedge clk) begin
        if (!rst) begin
            msg_q <= MSG_BLANK;
        end else if (addr_cycle) begin
            msg_q <= msg;
        end
    end

    assign col_idx  = ivl_q - 1'b1;
    assign rom_col  = (col_idx < interval_t'(LINE_TEXT_LEN)) ? col_idx[3:0]
                                                             : 4'(LINE_TEXT_LEN);
    assign rom_line = (state_q == LINE2);

    lcd_message_rom lcd_message_rom_inst (
        .msg  (msg_q),
        .line (rom_line),
        .col  (rom_col),
        .chr  (rom_chr)
    );

    always_ff @(posedge clk) begin
        if (!rst) begin
            lcd <= '0;
        end else begin
            lcd.e  <= (state_q != POWER_DELAY);
            lcd.rw <= 1'b0;
            lcd.rs <= 1'b0;
            case (state_q)
                POWER_DELAY:  lcd.data <= 8'h00;
                FUNCTION_SET: lcd.data <= CMD_FUNCTION;
                ENTRY_MODE:   lcd.data <= CMD_ENTRY;
                DISPLAY_ON:   lcd.data <= CMD_DISPLAY;
                LINE1, LINE2: begin
                    if (addr_cycle) begin
                        lcd.data <= (state_q == LINE1) ? CMD_LINE1 : CMD_LINE2;
                    end else begin
                        lcd.rs   <= 1'b1;       // Character write
                        lcd.data <= rom_chr;
                    end
                end
                RETURN_HOME:   lcd.data <= CMD_HOME;
                CLEAR_DISPLAY: lcd.data <= CMD_CLEAR;
            endcase
        end
    end

    a_no_read: assert property (
        @(posedge clk) disable iff (!rst)
        lcd.e |-> !lcd.rw
    );

    a_ivl_in_range: assert property (
        @(posedge clk) disable iff (!rst)
        ivl_q <= limit
    );

endmodule

`default_nettype wire

/* seven_seg/digit_decoder.sv */
`default_nettype none

module digit_decoder (
    input  wire                clk,
    input  wire                rst,
    input  wire board_pkg::digit_t digit,
    output board_pkg::seg_t    pattern
);

    import board_pkg::*;

    seg_t pattern_d;

    always_comb begin
        if (digit >= 3'd1 && digit <= 3'd5) begin
            pattern_d = SEG_DIGIT[digit];
        end else begin
            pattern_d = SEG_BLANK;              // 0, 6 and 7 show nothing
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            pattern <= SEG_BLANK;
        end else begin
            pattern <= pattern_d;
        end
    end

endmodule

`default_nettype wire

/* seven_seg/seg_scanner.sv */
`default_nettype none

module seg_scanner (
    input  wire              clk,
    input  wire              rst,
    input  wire board_pkg::seg_t pattern1,
    input  wire board_pkg::seg_t pattern2,
    output board_pkg::seg_t  seg,
    output board_pkg::pos_en_t pos_en
);

    import board_pkg::*;

    localparam logic [POS_W-1:0] LAST_POS = POS_W'(NUM_POS - 1);

    logic [POS_W-1:0] pos_q;
    pos_en_t          pos_sel;
    seg_t             seg_d;

    always_ff @(posedge clk) begin
        if (!rst) begin
            pos_q <= '0;
        end else if (pos_q == LAST_POS) begin
            pos_q <= '0;
        end else begin
            pos_q <= pos_q + 1'b1;
        end
    end

    always_comb begin
        pos_sel = '1;
        pos_sel[pos_q] = 1'b0;                  // Only current digit enabled

        if (pos_q == '0) begin
            seg_d = pattern1;
        end else if (pos_q == LAST_POS) begin
            seg_d = pattern2;
        end else begin
            seg_d = SEG_BLANK;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            seg    <= SEG_BLANK;
            pos_en <= '1;                       // Nothing selected
        end else begin
            seg    <= seg_d;
            pos_en <= pos_sel;
        end
    end

    // Outputs lag the counter by one cycle
    a_one_pos_active: assert property (
        @(posedge clk) disable iff (!rst)
        $past(rst) |-> $onehot(~pos_en)
    );

endmodule

`default_nettype wire

/* tb.f */
+incdir+bench
common/board_pkg.sv
verilog/player_leds.sv
seven_seg/digit_decoder.sv
seven_seg/seg_scanner.sv
lcd/lcd_message_rom.sv
lcd/lcd_sequencer.sv
verilog/game_display_top.sv
bench/tb_game_display.sv

/* verilog/game_display_top.sv */
`default_nettype none

module game_display_top (
    input  wire                     clk,
    input  wire                     rst,
    input  wire board_pkg::color_code_e color1,
    input  wire board_pkg::color_code_e color2,
    input  wire board_pkg::digit_t  digit1,
    input  wire board_pkg::digit_t  digit2,
    input  wire board_pkg::lcd_msg_e lcd_msg,
    output board_pkg::led_rgb_t     lamp1,
    output board_pkg::led_rgb_t     lamp2,
    output board_pkg::seg_t         seg,
    output board_pkg::pos_en_t      pos_en,
    output board_pkg::lcd_bus_t     lcd
);

    import board_pkg::*;

    seg_t pattern1;
    seg_t pattern2;

    player_leds player_leds_inst (
        .clk    (clk),
        .rst    (rst),
        .color1 (color1),
        .color2 (color2),
        .lamp1  (lamp1),
        .lamp2  (lamp2)
    );

    digit_decoder digit_decoder_1_inst (
        .clk     (clk),
        .rst     (rst),
        .digit   (digit1),
        .pattern (pattern1)
    );

    digit_decoder digit_decoder_2_inst (
        .clk     (clk),
        .rst     (rst),
        .digit   (digit2),
        .pattern (pattern2)
    );

    seg_scanner seg_scanner_inst (
        .clk      (clk),
        .rst      (rst),
        .pattern1 (pattern1),           // First position
        .pattern2 (pattern2),           // Last position
        .seg      (seg),
        .pos_en   (pos_en)
    );

    lcd_sequencer lcd_sequencer_inst (
        .clk (clk),
        .rst (rst),
        .msg (lcd_msg),
        .lcd (lcd)
    );

endmodule

`default_nettype wire

/* verilog/player_leds.sv */
`default_nettype none

module player_leds (
    input  wire                    clk,
    input  wire                    rst,
    input  wire board_pkg::color_code_e color1,
    input  wire board_pkg::color_code_e color2,
    output board_pkg::led_rgb_t    lamp1,
    output board_pkg::led_rgb_t    lamp2
);

    import board_pkg::*;

    function automatic led_rgb_t color_to_rgb(input color_code_e color);
        led_rgb_t rgb;
        rgb = '0;
        case (color)
            RED:     rgb.r = 1'b1;
            GREEN:   rgb.g = 1'b1;
            BLUE:    rgb.b = 1'b1;
            default: rgb = '0;                  // OFF
        endcase
        return rgb;
    endfunction

    always_ff @(posedge clk) begin
        if (!rst) begin
            lamp1 <= '0;
            lamp2 <= '0;
        end else begin
            lamp1 <= color_to_rgb(color1);
            lamp2 <= color_to_rgb(color2);
        end
    end

    a_lamp_one_hot: assert property (
        @(posedge clk) $onehot0(lamp1) && $onehot0(lamp2)
    );

endmodule

`default_nettype wire
